// ==== common/mmu_pkg.sv ====
// Sv32 only with no bare mode or ASIDs; physical addresses are 34 bits and a PTE PPN is bits 31:10
package mmu_pkg;

    // Address and entry widths for Sv32
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;

    // VPN[1] is bits 19:10, VPN[0] is bits 9:0
    typedef logic [19:0] vpn_t;

    // PPN[1] is bits 21:10, PPN[0] is bits 9:0
    typedef logic [21:0] ppn_t;

    // Raw page table entry as read from memory
    typedef logic [31:0] pte_t;

    // PTE flag bit positions
    localparam int unsigned pte_v = 0;
    localparam int unsigned pte_r = 1;
    localparam int unsigned pte_w = 2;
    localparam int unsigned pte_x = 3;

    // Page table walker states
    typedef enum logic [1:0] {
        ptw_idle,
        ptw_l1_read,
        ptw_l0_read,
        ptw_done
    } ptw_state_e;

    // MMU controller states
    typedef enum logic [1:0] {
        immu_idle,
        immu_walk,
        immu_resp
    } immu_state_e;

endpackage

// ==== itlb/itlb.sv ====
// Direct mapped, tlb_entries must be a power of two from 2 to 1024; flush beats a same-cycle update
`timescale 1ns/1ps

module itlb import mmu_pkg::*; #(
    parameter int tlb_entries = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  vpn_t lookup_vpn,
    input  logic flush,
    input  logic update,
    input  vpn_t update_vpn,
    input  pte_t update_pte,
    input  logic update_superpage,
    output logic hit,
    output pte_t hit_pte,
    output logic hit_superpage
);

    localparam int idx_w = $clog2(tlb_entries);

    // Entry storage, only valid bits are control state
    logic [tlb_entries-1:0] valid_q;
    logic [9:0]             vpn1_q [tlb_entries];
    logic [9:0]             vpn0_q [tlb_entries];
    pte_t                   pte_q  [tlb_entries];
    logic [tlb_entries-1:0] sp_q;

    logic [idx_w-1:0] r_index;
    logic [idx_w-1:0] w_index;

    // Index from low bits of VPN[1] so a superpage has one slot
    assign r_index = lookup_vpn[10 +: idx_w];
    assign w_index = update_vpn[10 +: idx_w];

    // Combinational lookup
    always_comb begin
        hit           = 1'b0;
        hit_pte       = '0;
        hit_superpage = 1'b0;
        if (valid_q[r_index] && (vpn1_q[r_index] == lookup_vpn[19:10])) begin
            // Superpage ignores VPN[0]
            if ((vpn0_q[r_index] == lookup_vpn[9:0]) || sp_q[r_index]) begin
                hit           = 1'b1;
                hit_pte       = pte_q[r_index];
                hit_superpage = sp_q[r_index];
            end
        end
    end

    // Valid bits, flush has priority
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (update) begin
            valid_q[w_index] <= 1'b1;
        end
    end

    // Payload write, overwrites whatever sits at the index
    always_ff @(posedge clk) begin
        if (update && !flush) begin
            vpn1_q[w_index] <= update_vpn[19:10];
            vpn0_q[w_index] <= update_vpn[9:0];
            pte_q[w_index]  <= update_pte;
            sp_q[w_index]   <= update_superpage;
        end
    end

endmodule

// ==== ptw/ptw.sv ====
// Read-only Wishbone classic master; no A/D updates or privilege checks, one walk at a time
`timescale 1ns/1ps

module ptw import mmu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  ppn_t   satp_ppn,
    input  logic   walk_start,
    input  vpn_t   walk_vpn,
    input  pte_t   wb_rdata,
    input  logic   wb_ack,
    output logic   walk_done,
    output pte_t   walk_pte,
    output logic   walk_superpage,
    output logic   walk_fault,
    output logic   wb_cyc,
    output logic   wb_stb,
    output paddr_t wb_adr
);

    ptw_state_e state;
    vpn_t       vpn_q;
    logic       rd_leaf;
    logic       rd_fault_l1;

    // Fault rules for one entry at a given level
    function automatic logic pte_fault(input pte_t pte, input logic level1);
        logic leaf;
        leaf = pte[pte_r] | pte[pte_x];
        pte_fault = 1'b0;
        // Invalid entry
        if (!pte[pte_v]) pte_fault = 1'b1;
        // Reserved write without read
        if (pte[pte_w] && !pte[pte_r]) pte_fault = 1'b1;
        // Pointer at the last level
        if (!leaf && !level1) pte_fault = 1'b1;
        // Leaf must allow execute
        if (leaf && !pte[pte_x]) pte_fault = 1'b1;
        // Superpage needs PPN[0] of zero
        if (leaf && level1 && (pte[19:10] != 10'd0)) pte_fault = 1'b1;
        return pte_fault;
    endfunction

    assign rd_leaf     = wb_rdata[pte_r] | wb_rdata[pte_x];
    assign rd_fault_l1 = pte_fault(wb_rdata, 1'b1);

    // Done is a one cycle pulse after the last ack
    assign walk_done = (state == ptw_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ptw_idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                ptw_idle: begin
                    if (walk_start) begin
                        vpn_q <= walk_vpn;
                        // satp.ppn * 4096 + VPN[1] * 4
                        wb_adr <= {satp_ppn, walk_vpn[19:10], 2'b00};
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= ptw_l1_read;
                    end
                end
                ptw_l1_read: begin
                    // Bus held stable until ack
                    if (wb_ack) begin
                        wb_cyc   <= 1'b0;
                        wb_stb   <= 1'b0;
                        walk_pte <= wb_rdata;
                        if (!rd_fault_l1 && !rd_leaf) begin
                            state <= ptw_l0_read;
                        end else begin
                            walk_fault     <= rd_fault_l1;
                            walk_superpage <= 1'b1;
                            state          <= ptw_done;
                        end
                    end
                end
                ptw_l0_read: begin
                    // One idle bus cycle after the level-1 ack
                    if (!wb_cyc) begin
                        // Pointer PPN * 4096 + VPN[0] * 4
                        wb_adr <= {walk_pte[31:10], vpn_q[9:0], 2'b00};
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end else if (wb_ack) begin
                        wb_cyc         <= 1'b0;
                        wb_stb         <= 1'b0;
                        walk_pte       <= wb_rdata;
                        walk_fault     <= pte_fault(wb_rdata, 1'b0);
                        walk_superpage <= 1'b0;
                        state          <= ptw_done;
                    end
                end
                ptw_done: begin
                    state <= ptw_idle;
                end
                default: begin
                    state <= ptw_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/immu.sv ====
// Requester holds fetch_vaddr until fetch_ack; faulted walks are returned but never cached
`timescale 1ns/1ps

module immu import mmu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   fetch_req,
    input  vaddr_t fetch_vaddr,
    input  logic   hit,
    input  pte_t   hit_pte,
    input  logic   hit_superpage,
    input  logic   walk_done,
    input  pte_t   walk_pte,
    input  logic   walk_superpage,
    input  logic   walk_fault,
    output logic   fetch_ack,
    output paddr_t fetch_paddr,
    output logic   fetch_fault,
    output vpn_t   lookup_vpn,
    output logic   walk_start,
    output vpn_t   walk_vpn,
    output logic   update,
    output vpn_t   update_vpn,
    output pte_t   update_pte,
    output logic   update_superpage
);

    immu_state_e state;
    pte_t        sel_pte;
    logic        sel_sp;
    paddr_t      paddr_next;

    // VPN stays valid through the ack cycle
    assign lookup_vpn = fetch_vaddr[31:12];
    assign walk_vpn   = fetch_vaddr[31:12];
    assign update_vpn = fetch_vaddr[31:12];

    // Ack cycle is the response state
    assign fetch_ack = (state == immu_resp);

    // Pick walker result while walking, else the TLB
    assign sel_pte = (state == immu_walk) ? walk_pte : hit_pte;
    assign sel_sp  = (state == immu_walk) ? walk_superpage : hit_superpage;

    // Physical address
    always_comb begin
        if (sel_sp) begin
            // PPN[1] * 4 MiB, VPN[0] and offset pass through
            paddr_next = {sel_pte[31:20], fetch_vaddr[21:0]};
        end else begin
            paddr_next = {sel_pte[31:10], fetch_vaddr[11:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= immu_idle;
            walk_start <= 1'b0;
            update     <= 1'b0;
        end else begin
            // Single cycle strobes
            walk_start <= 1'b0;
            update     <= 1'b0;
            case (state)
                immu_idle: begin
                    if (fetch_req) begin
                        if (hit) begin
                            fetch_paddr <= paddr_next;
                            fetch_fault <= 1'b0;
                            state       <= immu_resp;
                        end else begin
                            walk_start <= 1'b1;
                            state      <= immu_walk;
                        end
                    end
                end
                immu_walk: begin
                    if (walk_done) begin
                        fetch_paddr      <= paddr_next;
                        fetch_fault      <= walk_fault;
                        // Install only good translations
                        update           <= !walk_fault;
                        update_pte       <= walk_pte;
                        update_superpage <= walk_superpage;
                        state            <= immu_resp;
                    end
                end
                immu_resp: begin
                    // Request ignored during ack
                    state <= immu_idle;
                end
                default: begin
                    state <= immu_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/immu_top.sv ====
// Instruction MMU, Sv32 always on; page tables live outside behind a read-only Wishbone port
`timescale 1ns/1ps

module immu_top import mmu_pkg::*; #(
    parameter int tlb_entries = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   fetch_req,
    input  vaddr_t fetch_vaddr,
    input  logic   flush,
    input  ppn_t   satp_ppn,
    input  pte_t   wb_rdata,
    input  logic   wb_ack,
    output logic   fetch_ack,
    output paddr_t fetch_paddr,
    output logic   fetch_fault,
    output logic   wb_cyc,
    output logic   wb_stb,
    output paddr_t wb_adr
);

    // Controller to TLB
    vpn_t lookup_vpn;
    logic hit;
    pte_t hit_pte;
    logic hit_superpage;
    logic update;
    vpn_t update_vpn;
    pte_t update_pte;
    logic update_superpage;

    // Controller to walker
    logic walk_start;
    vpn_t walk_vpn;
    logic walk_done;
    pte_t walk_pte;
    logic walk_superpage;
    logic walk_fault;

    immu u_immu (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_req        (fetch_req),
        .fetch_vaddr      (fetch_vaddr),
        .hit              (hit),
        .hit_pte          (hit_pte),
        .hit_superpage    (hit_superpage),
        .walk_done        (walk_done),
        .walk_pte         (walk_pte),
        .walk_superpage   (walk_superpage),
        .walk_fault       (walk_fault),
        .fetch_ack        (fetch_ack),
        .fetch_paddr      (fetch_paddr),
        .fetch_fault      (fetch_fault),
        .lookup_vpn       (lookup_vpn),
        .walk_start       (walk_start),
        .walk_vpn         (walk_vpn),
        .update           (update),
        .update_vpn       (update_vpn),
        .update_pte       (update_pte),
        .update_superpage (update_superpage)
    );

    itlb #(
        .tlb_entries (tlb_entries)
    ) u_itlb (
        .clk              (clk),
        .rst_n            (rst_n),
        .lookup_vpn       (lookup_vpn),
        .flush            (flush),
        .update           (update),
        .update_vpn       (update_vpn),
        .update_pte       (update_pte),
        .update_superpage (update_superpage),
        .hit              (hit),
        .hit_pte          (hit_pte),
        .hit_superpage    (hit_superpage)
    );

    ptw u_ptw (
        .clk            (clk),
        .rst_n          (rst_n),
        .satp_ppn       (satp_ppn),
        .walk_start     (walk_start),
        .walk_vpn       (walk_vpn),
        .wb_rdata       (wb_rdata),
        .wb_ack         (wb_ack),
        .walk_done      (walk_done),
        .walk_pte       (walk_pte),
        .walk_superpage (walk_superpage),
        .walk_fault     (walk_fault),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Free-running testbench clock, starts low, default period 40 ns
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period_ns = 20
) (
    output logic clk
);

    // Single process so the clock has one driver
    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

endmodule

// ==== testbench/immu_checker.sv ====
// Bound to immu_top; reports through assertion failures only, sampled on the rising edge
`timescale 1ns/1ps

module immu_checker import mmu_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   fetch_req,
    input logic   fetch_ack,
    input logic   wb_cyc,
    input logic   wb_stb,
    input logic   wb_ack,
    input paddr_t wb_adr
);

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // Address held through slave wait states
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed while waiting for wb_ack");

    // One cycle ack pulse
    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) fetch_ack |=> !fetch_ack)
        else $error("fetch_ack high for more than one cycle");

    // No ack without a request
    ack_has_req: assert property (@(posedge clk) disable iff (!rst_n) fetch_ack |-> fetch_req)
        else $error("fetch_ack without fetch_req");

    // Bus idle right out of reset
    cyc_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_cyc)
        else $error("wb_cyc high in the cycle after reset");

endmodule

bind immu_top immu_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_req (fetch_req),
    .fetch_ack (fetch_ack),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .wb_adr    (wb_adr)
);

// ==== testbench/immu_tb.sv ====
// Directed tests; page tables sit in a sparse memory that answers as a Wishbone slave
`timescale 1ns/1ps

module immu_tb import mmu_pkg::*; ();

    localparam ppn_t satp_root = 22'h00100;
    localparam int   max_wait  = 3;
    // Start, two reads with an idle gap, done and ack
    localparam int   walk_cycles = 2 * (max_wait + 1) + 6;
    localparam int   num_tests = 6;
    localparam int   fetches_per_test = 12;
    localparam int   watchdog_ns = (num_tests * fetches_per_test * (walk_cycles + 4) + 10) * 40;

    localparam vaddr_t va_page  = 32'h0040_3abc;
    localparam vaddr_t va_page2 = 32'h0040_3010;
    localparam vaddr_t va_sp    = 32'h0080_5123;
    localparam vaddr_t va_sp2   = 32'h0080_9456;
    // Same TLB index as va_page
    localparam vaddr_t va_alias = 32'h0340_0200;

    logic   clk;
    logic   rst_n;
    logic   fetch_req;
    vaddr_t fetch_vaddr;
    logic   flush;
    ppn_t   satp_ppn;
    pte_t   wb_rdata = '0;
    logic   wb_ack = 1'b0;
    logic   fetch_ack;
    paddr_t fetch_paddr;
    logic   fetch_fault;
    logic   wb_cyc;
    logic   wb_stb;
    paddr_t wb_adr;

    // Page table memory keyed by byte address
    pte_t   mem [paddr_t];
    paddr_t bus_log [$];
    int     seed = 32'h403b_83bd;
    int     wait_left = 0;
    logic   in_cycle = 1'b0;

    // Result of the last fetch
    paddr_t got_paddr;
    logic   got_fault;
    int     got_latency;
    int     got_reads;
    int     log_start;
    pte_t   page_ptr;
    pte_t   page_leaf;
    pte_t   sp_leaf;

    tb_clock_gen #(.half_period_ns(20)) u_clock (.clk(clk));

    immu_top #(.tlb_entries(4)) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_vaddr (fetch_vaddr),
        .flush       (flush),
        .satp_ppn    (satp_ppn),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .fetch_ack   (fetch_ack),
        .fetch_paddr (fetch_paddr),
        .fetch_fault (fetch_fault),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr)
    );

    // Wishbone slave with 0 to max_wait wait states per read
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_ack) begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = {$random(seed)} % (max_wait + 1);
                bus_log.push_back(wb_adr);
            end
            if (wait_left == 0) begin
                wb_ack   = 1'b1;
                // Unwritten entries read as invalid
                wb_rdata = mem.exists(wb_adr) ? mem[wb_adr] : '0;
            end else begin
                wait_left--;
            end
        end
    end

    // Sv32 address rules
    function automatic paddr_t l1_entry_addr(input vaddr_t va);
        return paddr_t'(satp_root) * 34'd4096 + paddr_t'(va[31:22]) * 34'd4;
    endfunction

    function automatic paddr_t l0_entry_addr(input pte_t ptr, input vaddr_t va);
        return paddr_t'(ptr[31:10]) * 34'd4096 + paddr_t'(va[21:12]) * 34'd4;
    endfunction

    function automatic paddr_t page_pa(input pte_t leaf, input vaddr_t va);
        return paddr_t'(leaf[31:10]) * 34'd4096 + paddr_t'(va[11:0]);
    endfunction

    // PPN[1] * 4 MiB, VPN[0] * 4 KiB, then the offset
    function automatic paddr_t superpage_pa(input pte_t leaf, input vaddr_t va);
        return paddr_t'(leaf[31:20]) * 34'h40_0000 + paddr_t'(va[21:12]) * 34'd4096
            + paddr_t'(va[11:0]);
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic v, input logic r,
                                      input logic w, input logic x);
        pte_t p;
        p = {ppn, 10'd0};
        p[pte_v] = v;
        p[pte_r] = r;
        p[pte_w] = w;
        p[pte_x] = x;
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bus_adr(input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL wb_adr got %h expected %h", got, exp));
        end
    endtask

    // Request held through the ack cycle and dropped in the cycle after
    task automatic run_fetch(input vaddr_t va);
        int cycles;
        cycles = 0;
        @(negedge clk);
        log_start   = bus_log.size();
        fetch_req   = 1'b1;
        fetch_vaddr = va;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > walk_cycles + 4) begin
                abort_run($sformatf("no fetch_ack for address %h within the walk time", va));
            end
        end while (fetch_ack !== 1'b1);
        got_paddr   = fetch_paddr;
        got_fault   = fetch_fault;
        got_latency = cycles;
        got_reads   = bus_log.size() - log_start;
        @(negedge clk);
        fetch_req   = 1'b0;
        fetch_vaddr = '0;
    endtask

    task automatic expect_hit(input vaddr_t va, input paddr_t exp_pa);
        run_fetch(va);
        if (got_latency != 1) begin
            abort_run($sformatf("hit on %h took %0d cycles instead of one", va, got_latency));
        end
        check_flag("wb_cyc", got_reads != 0, 1'b0);
        check_flag("fetch_fault", got_fault, 1'b0);
        check_paddr("fetch_paddr", got_paddr, exp_pa);
    endtask

    task automatic expect_walk(input vaddr_t va, input int n_reads, input paddr_t adr_l1,
                               input paddr_t adr_l0, input logic exp_fault,
                               input paddr_t exp_pa);
        run_fetch(va);
        if (got_reads != n_reads) begin
            abort_run($sformatf("fetch of %h made %0d bus reads instead of %0d",
                                va, got_reads, n_reads));
        end
        check_bus_adr(bus_log[log_start], adr_l1);
        if (n_reads == 2) begin
            check_bus_adr(bus_log[log_start + 1], adr_l0);
        end
        check_flag("fetch_fault", got_fault, exp_fault);
        if (!exp_fault) begin
            check_paddr("fetch_paddr", got_paddr, exp_pa);
        end
    endtask

    // Faults are not cached so the second fetch walks again
    task automatic fault_twice(input vaddr_t va, input int n_reads, input pte_t ptr);
        repeat (2) begin
            expect_walk(va, n_reads, l1_entry_addr(va), l0_entry_addr(ptr, va), 1'b1, '0);
        end
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic test_page_miss();
        page_ptr  = make_pte(22'h00101, 1'b1, 1'b0, 1'b0, 1'b0);
        page_leaf = make_pte(22'h23456, 1'b1, 1'b1, 1'b0, 1'b1);
        mem[l1_entry_addr(va_page)] = page_ptr;
        mem[l0_entry_addr(page_ptr, va_page)] = page_leaf;
        expect_walk(va_page, 2, l1_entry_addr(va_page), l0_entry_addr(page_ptr, va_page),
                    1'b0, page_pa(page_leaf, va_page));
    endtask

    task automatic test_page_hit();
        expect_hit(va_page2, page_pa(page_leaf, va_page2));
    endtask

    task automatic test_superpage();
        sp_leaf = make_pte(22'h30c00, 1'b1, 1'b1, 1'b0, 1'b1);
        mem[l1_entry_addr(va_sp)] = sp_leaf;
        expect_walk(va_sp, 1, l1_entry_addr(va_sp), '0, 1'b0, superpage_pa(sp_leaf, va_sp));
        // Different VPN[0] under the same VPN[1]
        expect_hit(va_sp2, superpage_pa(sp_leaf, va_sp2));
    endtask

    task automatic test_faults();
        pte_t ptr_a;
        pte_t ptr_b;
        ptr_a = make_pte(22'h00102, 1'b1, 1'b0, 1'b0, 1'b0);
        ptr_b = make_pte(22'h00104, 1'b1, 1'b0, 1'b0, 1'b0);
        // Invalid level-1 entry since nothing is written there
        fault_twice(32'h0140_0040, 1, '0);
        // Write without read
        mem[l1_entry_addr(32'h0180_0123)] = make_pte(22'h00200, 1'b1, 1'b0, 1'b1, 1'b1);
        fault_twice(32'h0180_0123, 1, '0);
        // Pointer found at level 0
        mem[l1_entry_addr(32'h01c0_1010)] = ptr_a;
        mem[l0_entry_addr(ptr_a, 32'h01c0_1010)] = make_pte(22'h00103, 1'b1, 1'b0, 1'b0, 1'b0);
        fault_twice(32'h01c0_1010, 2, ptr_a);
        // Leaf without execute
        mem[l1_entry_addr(32'h0240_2020)] = ptr_b;
        mem[l0_entry_addr(ptr_b, 32'h0240_2020)] = make_pte(22'h12345, 1'b1, 1'b1, 1'b0, 1'b0);
        fault_twice(32'h0240_2020, 2, ptr_b);
        // Superpage with nonzero PPN[0]
        mem[l1_entry_addr(32'h0280_0030)] = make_pte(22'h30c01, 1'b1, 1'b1, 1'b0, 1'b1);
        fault_twice(32'h0280_0030, 1, '0);
    endtask

    task automatic test_flush();
        expect_hit(va_page2, page_pa(page_leaf, va_page2));
        pulse_flush();
        expect_walk(va_page, 2, l1_entry_addr(va_page), l0_entry_addr(page_ptr, va_page),
                    1'b0, page_pa(page_leaf, va_page));
        expect_hit(va_page, page_pa(page_leaf, va_page));
    endtask

    task automatic test_eviction();
        pte_t ptr;
        pte_t leaf;
        ptr  = make_pte(22'h00105, 1'b1, 1'b0, 1'b0, 1'b0);
        leaf = make_pte(22'h05555, 1'b1, 1'b1, 1'b1, 1'b1);
        mem[l1_entry_addr(va_alias)] = ptr;
        mem[l0_entry_addr(ptr, va_alias)] = leaf;
        // Refill the other index after the flush
        expect_walk(va_sp, 1, l1_entry_addr(va_sp), '0, 1'b0, superpage_pa(sp_leaf, va_sp));
        expect_walk(va_alias, 2, l1_entry_addr(va_alias), l0_entry_addr(ptr, va_alias),
                    1'b0, page_pa(leaf, va_alias));
        expect_walk(va_page, 2, l1_entry_addr(va_page), l0_entry_addr(page_ptr, va_page),
                    1'b0, page_pa(page_leaf, va_page));
        expect_walk(va_alias, 2, l1_entry_addr(va_alias), l0_entry_addr(ptr, va_alias),
                    1'b0, page_pa(leaf, va_alias));
        expect_hit(va_alias, page_pa(leaf, va_alias));
        // Other index untouched
        expect_hit(va_sp2, superpage_pa(sp_leaf, va_sp2));
    endtask

    initial begin
        #(watchdog_ns);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rst_n       = 1'b0;
        fetch_req   = 1'b0;
        fetch_vaddr = '0;
        flush       = 1'b0;
        satp_ppn    = satp_root;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_page_miss();
        test_page_hit();
        test_superpage();
        test_faults();
        test_flush();
        test_eviction();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
common/mmu_pkg.sv
itlb/itlb.sv
ptw/ptw.sv
src/immu.sv
src/immu_top.sv
testbench/tb_clock_gen.sv
testbench/immu_checker.sv
testbench/immu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the instruction MMU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module immu_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vimmu_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without finishing the tests"
    exit 1
fi

exit 0
